/* digit_view.f */
src/digit_view_pkg.sv
src/vga_timing.sv
src/digit_font_rom.sv
src/scroll.sv
src/vga_out_stage.sv
src/seven_hex_16_4.sv
src/digit_view_top.sv
verification/tb_digit_view.sv

/* src/digit_font_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module digit_font_rom (
    input  wire logic [3:0] i_digit,
    input  wire logic [2:0] i_row,
    output logic [7:0]      o_bits
);

    // whole glyph, row 0 in the top byte
    logic [63:0] glyph;

    always_comb begin
        case (i_digit)
            4'd0:    glyph = 64'h3C66_6E76_6666_3C00;
            4'd1:    glyph = 64'h1838_1818_1818_7E00;
            4'd2:    glyph = 64'h3C66_060C_3060_7E00;
            4'd3:    glyph = 64'h3C66_061C_0666_3C00;
            4'd4:    glyph = 64'h0C1C_3C6C_7E0C_0C00;
            4'd5:    glyph = 64'h7E60_7C06_0666_3C00;
            4'd6:    glyph = 64'h3C60_607C_6666_3C00;
            4'd7:    glyph = 64'h7E06_0C18_3030_3000;
            4'd8:    glyph = 64'h3C66_663C_6666_3C00;
            4'd9:    glyph = 64'h3C66_663E_060C_3800;
            // no glyph above 9
            default: glyph = 64'h0;
        endcase
    end

    // bit 7 is the leftmost pixel of the row
    assign o_bits = glyph[8*(7-i_row) +: 8];

endmodule

`default_nettype wire

/* src/digit_view_pkg.sv */
`default_nettype none

package digit_view_pkg;

    // 640x480 at 60 Hz, 25 MHz pixel clock
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // sync windows, pulses are active low
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;

    // handwriting box, 30x30 cells of 8x8 pixels
    localparam int BOX_X0   = 200;
    localparam int BOX_Y0   = 120;
    localparam int BM_SIZE  = 30;
    localparam int CELL     = 8;
    localparam int BOX_SIZE = BM_SIZE * CELL;
    // ring drawn just outside the box
    localparam int BORDER   = 2;

    // answer glyph window, 8x8 font scaled like the cells
    localparam int GLYPH_X0   = 480;
    localparam int GLYPH_Y0   = 184;
    localparam int FONT_W     = 8;
    localparam int GLYPH_SIZE = FONT_W * CELL;

    localparam int COLOR_W = 10;
    localparam int FRAME_W = 12;

    // raster state of one pixel
    typedef struct packed {
        logic [10:0] x;
        logic [10:0] y;
        logic        hs;
        logic        vs;
        logic        active;
    } vga_timing_t;

    // one pixel colour
    typedef struct packed {
        logic [COLOR_W-1:0] red;
        logic [COLOR_W-1:0] green;
        logic [COLOR_W-1:0] blue;
    } rgb_t;

    // syncs idle high, video off
    localparam vga_timing_t TIMING_IDLE = '{x: '0, y: '0, hs: 1'b1, vs: 1'b1, active: 1'b0};

    localparam rgb_t C_BLACK = '{red: '0, green: '0, blue: '0};
    localparam rgb_t C_WHITE = '{red: '1, green: '1, blue: '1};
    localparam rgb_t C_BG    = '{red: 10'h100, green: 10'h100, blue: 10'h100};
    localparam rgb_t C_GREEN = '{red: '0, green: '1, blue: '0};
    localparam rgb_t C_RED   = '{red: '1, green: '0, blue: '0};
    localparam rgb_t C_BLUE  = '{red: '0, green: '0, blue: '1};

endpackage

`default_nettype wire

/* src/digit_view_top.sv */
`timescale 1ns/1ps
`default_nettype none

module digit_view_top
    import digit_view_pkg::*;
(
    input  wire logic          i_clk,
    input  wire logic          i_rst_n,
    input  wire logic [899:0]  i_handwrite,
    input  wire logic [3:0]    i_digit_answered,
    input  wire logic          i_digit_identified,
    output logic [7:0]         o_vga_r,
    output logic [7:0]         o_vga_g,
    output logic [7:0]         o_vga_b,
    output logic               o_vga_hs,
    output logic               o_vga_vs,
    output logic               o_vga_blank_n,
    output logic [6:0]         o_hex3,
    output logic [6:0]         o_hex2,
    output logic [6:0]         o_hex1,
    output logic [6:0]         o_hex0
);

    vga_timing_t          timing;
    logic [FRAME_W-1:0]   frame_cnt;
    rgb_t                 rgb;

    // raster generator
    vga_timing u_timing (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .o_timing    (timing),
        .o_frame_cnt (frame_cnt)
    );

    // pixel colour, one cycle behind timing
    scroll u_scroll (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_timing           (timing),
        .i_frame_cnt        (frame_cnt),
        .i_handwrite        (i_handwrite),
        .i_digit_answered   (i_digit_answered),
        .i_digit_identified (i_digit_identified),
        .o_rgb              (rgb)
    );

    // pins, two cycles behind timing
    vga_out_stage u_out (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_timing      (timing),
        .i_rgb         (rgb),
        .o_vga_r       (o_vga_r),
        .o_vga_g       (o_vga_g),
        .o_vga_b       (o_vga_b),
        .o_vga_hs      (o_vga_hs),
        .o_vga_vs      (o_vga_vs),
        .o_vga_blank_n (o_vga_blank_n)
    );

    // frame count on hex3..hex1, answer on hex0
    seven_hex_16_4 u_hex (
        .i_hex     ({frame_cnt[11:0], i_digit_answered}),
        .o_seven_3 (o_hex3),
        .o_seven_2 (o_hex2),
        .o_seven_1 (o_hex1),
        .o_seven_0 (o_hex0)
    );

endmodule

`default_nettype wire

/* src/scroll.sv */
`timescale 1ns/1ps
`default_nettype none

module scroll
    import digit_view_pkg::*;
(
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire vga_timing_t         i_timing,
    input  wire logic [FRAME_W-1:0]  i_frame_cnt,
    input  wire logic [899:0]        i_handwrite,
    input  wire logic [3:0]          i_digit_answered,
    input  wire logic                i_digit_identified,
    output rgb_t                     o_rgb
);

    // offsets from the box and glyph corners
    logic [10:0] box_dx;
    logic [10:0] box_dy;
    logic [10:0] gl_dx;
    logic [10:0] gl_dy;

    logic        in_box;
    logic        in_ring;
    logic        in_glyph;

    logic [9:0]  bm_idx;
    logic [5:0]  scroll_line;
    logic [7:0]  font_bits;
    logic        font_px;
    rgb_t        rgb_next;

    assign box_dx = i_timing.x - 11'(BOX_X0);
    assign box_dy = i_timing.y - 11'(BOX_Y0);
    assign gl_dx  = i_timing.x - 11'(GLYPH_X0);
    assign gl_dy  = i_timing.y - 11'(GLYPH_Y0);

    // region tests
    assign in_box = (i_timing.x >= 11'(BOX_X0)) && (i_timing.x < 11'(BOX_X0 + BOX_SIZE))
                 && (i_timing.y >= 11'(BOX_Y0)) && (i_timing.y < 11'(BOX_Y0 + BOX_SIZE));

    // ring test includes the box, priority sorts it out
    assign in_ring = (i_timing.x >= 11'(BOX_X0 - BORDER))
                  && (i_timing.x < 11'(BOX_X0 + BOX_SIZE + BORDER))
                  && (i_timing.y >= 11'(BOX_Y0 - BORDER))
                  && (i_timing.y < 11'(BOX_Y0 + BOX_SIZE + BORDER));

    assign in_glyph = (i_timing.x >= 11'(GLYPH_X0)) && (i_timing.x < 11'(GLYPH_X0 + GLYPH_SIZE))
                   && (i_timing.y >= 11'(GLYPH_Y0)) && (i_timing.y < 11'(GLYPH_Y0 + GLYPH_SIZE));

    // cell index row*30+col, 8 pixels per cell
    assign bm_idx = 10'(box_dy[7:3]) * 10'(BM_SIZE) + 10'(box_dx[7:3]);

    // one glyph line per frame, wraps at 64
    assign scroll_line = gl_dy[5:0] + i_frame_cnt[5:0];

    digit_font_rom u_font (
        .i_digit (i_digit_answered),
        .i_row   (scroll_line[5:3]),
        .o_bits  (font_bits)
    );

    // font column from the scaled x offset
    assign font_px = font_bits[3'd7 - gl_dx[5:3]];

    always_comb begin
        if (!i_timing.active) begin
            rgb_next = C_BLACK;
        end else if (in_box) begin
            rgb_next = i_handwrite[bm_idx] ? C_WHITE : C_BLACK;
        end else if (in_ring) begin
            // green once a digit is recognised
            rgb_next = i_digit_identified ? C_GREEN : C_RED;
        end else if (in_glyph) begin
            rgb_next = font_px ? C_BLUE : C_BLACK;
        end else begin
            rgb_next = C_BG;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_rgb <= C_BLACK;
        end else begin
            o_rgb <= rgb_next;
        end
    end

    // blanking pixels leave here black
    a_blank_black: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !$past(i_timing.active) |-> (o_rgb == C_BLACK)
    );

endmodule

`default_nettype wire

/* src/seven_hex_16_4.sv */
`timescale 1ns/1ps
`default_nettype none

module seven_hex_16_4 (
    input  wire logic [15:0] i_hex,
    output logic [6:0]       o_seven_3,
    output logic [6:0]       o_seven_2,
    output logic [6:0]       o_seven_1,
    output logic [6:0]       o_seven_0
);

    // active low, g at bit 6 down to a at bit 0
    function automatic logic [6:0] seg_decode(input logic [3:0] nib);
        case (nib)
            4'h0:    seg_decode = 7'b1000000;
            4'h1:    seg_decode = 7'b1111001;
            4'h2:    seg_decode = 7'b0100100;
            4'h3:    seg_decode = 7'b0110000;
            4'h4:    seg_decode = 7'b0011001;
            4'h5:    seg_decode = 7'b0010010;
            4'h6:    seg_decode = 7'b0000010;
            4'h7:    seg_decode = 7'b1111000;
            4'h8:    seg_decode = 7'b0000000;
            4'h9:    seg_decode = 7'b0010000;
            4'hA:    seg_decode = 7'b0001000;
            4'hB:    seg_decode = 7'b0000011;
            4'hC:    seg_decode = 7'b1000110;
            4'hD:    seg_decode = 7'b0100001;
            4'hE:    seg_decode = 7'b0000110;
            default: seg_decode = 7'b0001110;
        endcase
    endfunction

    // digit 3 carries the top nibble
    assign o_seven_3 = seg_decode(i_hex[15:12]);
    assign o_seven_2 = seg_decode(i_hex[11:8]);
    assign o_seven_1 = seg_decode(i_hex[7:4]);
    assign o_seven_0 = seg_decode(i_hex[3:0]);

endmodule

`default_nettype wire

/* src/vga_out_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_out_stage
    import digit_view_pkg::*;
(
    input  wire logic         i_clk,
    input  wire logic         i_rst_n,
    input  wire vga_timing_t  i_timing,
    input  wire rgb_t         i_rgb,
    output logic [7:0]        o_vga_r,
    output logic [7:0]        o_vga_g,
    output logic [7:0]        o_vga_b,
    output logic              o_vga_hs,
    output logic              o_vga_vs,
    output logic              o_vga_blank_n
);

    // timing lined up with the renderer register
    vga_timing_t timing_d;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            timing_d      <= TIMING_IDLE;
            o_vga_r       <= '0;
            o_vga_g       <= '0;
            o_vga_b       <= '0;
            o_vga_hs      <= 1'b1;
            o_vga_vs      <= 1'b1;
            o_vga_blank_n <= 1'b0;
        end else begin
            timing_d      <= i_timing;
            // top 8 bits of each 10 bit channel
            o_vga_r       <= i_rgb.red[COLOR_W-1 -: 8];
            o_vga_g       <= i_rgb.green[COLOR_W-1 -: 8];
            o_vga_b       <= i_rgb.blue[COLOR_W-1 -: 8];
            o_vga_hs      <= timing_d.hs;
            o_vga_vs      <= timing_d.vs;
            o_vga_blank_n <= timing_d.active;
        end
    end

    // colour and blank from separate paths must agree
    a_blank_no_colour: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !o_vga_blank_n |-> ((o_vga_r == 8'd0) && (o_vga_g == 8'd0) && (o_vga_b == 8'd0))
    );

endmodule

`default_nettype wire

/* src/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing
    import digit_view_pkg::*;
(
    input  wire logic               i_clk,
    input  wire logic               i_rst_n,
    output vga_timing_t             o_timing,
    output logic [FRAME_W-1:0]      o_frame_cnt
);

    // free running raster position
    logic [10:0] h_cnt;
    logic [10:0] v_cnt;
    logic        h_last;
    logic        v_last;

    assign h_last = (h_cnt == 11'(H_TOTAL - 1));
    assign v_last = (v_cnt == 11'(V_TOTAL - 1));

    // counters plus frame count
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            o_frame_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
                // x and y wrap together here
                v_cnt       <= '0;
                o_frame_cnt <= o_frame_cnt + 1'b1;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // registered decode, one cycle behind the counters
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_timing <= TIMING_IDLE;
        end else begin
            o_timing.x      <= h_cnt;
            o_timing.y      <= v_cnt;
            // low inside the sync window
            o_timing.hs     <= !((h_cnt >= 11'(HS_START)) && (h_cnt < 11'(HS_END)));
            o_timing.vs     <= !((v_cnt >= 11'(VS_START)) && (v_cnt < 11'(VS_END)));
            o_timing.active <= (h_cnt < 11'(H_ACTIVE)) && (v_cnt < 11'(V_ACTIVE));
        end
    end

    // line length stays at 800
    a_h_cnt_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        h_cnt < 11'(H_TOTAL)
    );

endmodule

`default_nettype wire

/* verification/digit_view_golden.txt */
# bitmap: 3 lines of five 60-bit hex words (two rows each, bit 899 first); answer identified;
# hex3 hex2 hex1 hex0 for frames 0 and 1; then samples: frame x y rgb (24-bit hex)
000000000000000 00000000003f000 00030000000c000 00030000000c000 00030000000c000
00030000000c000 00030000000c000 00030000000c000 00030000000c000 00030000000c000
00030000000c000 00030000000c000 00038000000c000 000000000000000 000000000000000
3 1
40 40 40 30
40 40 79 30
0 315 205 ffffff
0 329 205 000000
1 304 160 ffffff
1 296 335 ffffff
0 315 336 000000
0 198 200 00ff00
1 441 361 00ff00
0 300 118 00ff00
0 0 0 404040
1 639 479 404040
0 197 200 404040
0 492 191 000000
1 492 191 0000ff
0 504 191 0000ff
1 504 191 000000
1 496 247 0000ff

/* verification/tb_digit_view.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_digit_view;

    localparam int CLK_PERIOD   = 8;
    localparam int FRAME_CYCLES = 420000;
    localparam int MAX_SAMPLES  = 16;
    // 640x480 raster seen at the pins
    localparam int LINE_PIXELS  = 640;
    localparam int LINE_CYCLES  = 800;
    localparam int HS_WIDTH     = 96;
    localparam int FRAME_LINES  = 480;
    localparam int VS_WIDTH     = 2 * LINE_CYCLES;

    logic         i_clk = 1'b0;
    logic         i_rst_n;
    logic [899:0] i_handwrite;
    logic [3:0]   i_digit_answered;
    logic         i_digit_identified;
    logic [7:0]   o_vga_r;
    logic [7:0]   o_vga_g;
    logic [7:0]   o_vga_b;
    logic         o_vga_hs;
    logic         o_vga_vs;
    logic         o_vga_blank_n;
    logic [6:0]   o_hex3;
    logic [6:0]   o_hex2;
    logic [6:0]   o_hex1;
    logic [6:0]   o_hex0;

    // golden data
    int           fd;
    logic [899:0] gold_hw;
    logic [3:0]   gold_answer;
    logic         gold_ident;
    logic [6:0]   gold_hex [0:1][0:3];
    int           s_frame [MAX_SAMPLES];
    int           s_x [MAX_SAMPLES];
    int           s_y [MAX_SAMPLES];
    logic [23:0]  s_rgb [MAX_SAMPLES];
    int           n_samples = 0;

    // position rebuilt from the pins
    int cyc = 0;
    int x_cnt = 0;
    int y_cnt = 0;
    int frame_num = 0;
    int hs_low = 0;
    int vs_low = 0;
    int last_hs_fall = 0;
    int hits = 0;
    int hex_checks = 0;
    bit hs_seen = 1'b0;
    bit rst_d = 1'b0;
    bit prev_hs = 1'b1;
    bit prev_vs = 1'b1;
    bit prev_blank = 1'b0;
    int errors = 0;
    int checks = 0;

    digit_view_top i_dut (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_handwrite        (i_handwrite),
        .i_digit_answered   (i_digit_answered),
        .i_digit_identified (i_digit_identified),
        .o_vga_r            (o_vga_r),
        .o_vga_g            (o_vga_g),
        .o_vga_b            (o_vga_b),
        .o_vga_hs           (o_vga_hs),
        .o_vga_vs           (o_vga_vs),
        .o_vga_blank_n      (o_vga_blank_n),
        .o_hex3             (o_hex3),
        .o_hex2             (o_hex2),
        .o_hex1             (o_hex1),
        .o_hex0             (o_hex0)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // next line that is neither blank nor a comment
    task automatic next_record(output string line, output bit ok);
        int rc;
        ok = 1'b0;
        line = "";
        while (!ok && !$feof(fd)) begin
            rc = $fgets(line, fd);
            ok = (rc > 0) && (line.len() > 1) && (line.getc(0) != "#");
        end
    endtask

    task automatic load_golden();
        string       line;
        bit          ok;
        int          rc;
        int          bad;
        logic [59:0] w [0:4];
        bad = 0;
        fd = $fopen("verification/digit_view_golden.txt", "r");
        if (fd != 0) begin
            // bitmap, five 60-bit words per line, bit 899 first
            gold_hw = '0;
            for (int i = 0; i < 3; i++) begin
                next_record(line, ok);
                rc = $sscanf(line, "%h %h %h %h %h", w[0], w[1], w[2], w[3], w[4]);
                if (!ok || rc != 5) begin
                    bad = bad + 1;
                end
                gold_hw = {gold_hw[599:0], w[0], w[1], w[2], w[3], w[4]};
            end
            next_record(line, ok);
            rc = $sscanf(line, "%d %d", gold_answer, gold_ident);
            if (!ok || rc != 2) begin
                bad = bad + 1;
            end
            // hex patterns for frame 0 and frame 1
            for (int fr = 0; fr < 2; fr++) begin
                next_record(line, ok);
                rc = $sscanf(line, "%h %h %h %h", gold_hex[fr][0], gold_hex[fr][1],
                             gold_hex[fr][2], gold_hex[fr][3]);
                if (!ok || rc != 4) begin
                    bad = bad + 1;
                end
            end
            next_record(line, ok);
            while (ok && n_samples < MAX_SAMPLES) begin
                rc = $sscanf(line, "%d %d %d %h", s_frame[n_samples], s_x[n_samples],
                             s_y[n_samples], s_rgb[n_samples]);
                if (rc != 4) begin
                    bad = bad + 1;
                end
                n_samples = n_samples + 1;
                next_record(line, ok);
            end
            $fclose(fd);
            if (bad != 0) begin
                $display("golden file has %0d malformed records", bad);
                errors = errors + 1;
            end
        end
    endtask

    // pins sampled on the falling edge, halfway between updates
    always @(negedge i_clk) begin : pin_monitor
        logic [27:0] hex_act;
        cyc = cyc + 1;
        if (!i_rst_n || !rst_d) begin
            // idle pins in reset and one cycle after
            check_value("reset hs vs", 2'b11, {o_vga_hs, o_vga_vs});
            check_value("reset blank_n", 1'b0, o_vga_blank_n);
            check_value("reset colour", 24'h0, {o_vga_r, o_vga_g, o_vga_b});
        end else begin
            if (!o_vga_hs) begin
                hs_low = hs_low + 1;
            end
            if (!o_vga_vs) begin
                vs_low = vs_low + 1;
            end
            if (prev_hs && !o_vga_hs) begin
                if (hs_seen) begin
                    check_value("hsync period", LINE_CYCLES, cyc - last_hs_fall);
                end
                hs_seen = 1'b1;
                last_hs_fall = cyc;
            end
            if (!prev_hs && o_vga_hs) begin
                check_value("hsync width", HS_WIDTH, hs_low);
                hs_low = 0;
            end
            if (!prev_vs && o_vga_vs) begin
                check_value("vsync width", VS_WIDTH, vs_low);
                vs_low = 0;
            end
            if (o_vga_blank_n) begin
                // hex digits at the first pixel of each frame
                if (x_cnt == 0 && y_cnt == 0 && frame_num < 2) begin
                    hex_act = {o_hex3, o_hex2, o_hex1, o_hex0};
                    for (int d = 0; d < 4; d++) begin
                        check_value($sformatf("hex%0d frame %0d", 3 - d, frame_num),
                                    gold_hex[frame_num][d], hex_act[7*(3-d) +: 7]);
                    end
                    hex_checks = hex_checks + 1;
                end
                for (int i = 0; i < n_samples; i++) begin
                    if (s_frame[i] == frame_num && s_x[i] == x_cnt && s_y[i] == y_cnt) begin
                        check_value($sformatf("pixel f%0d (%0d,%0d)", frame_num, x_cnt, y_cnt),
                                    s_rgb[i], {o_vga_r, o_vga_g, o_vga_b});
                        hits = hits + 1;
                    end
                end
                x_cnt = x_cnt + 1;
            end else if (prev_blank) begin
                check_value("active pixels per line", LINE_PIXELS, x_cnt);
                x_cnt = 0;
                y_cnt = y_cnt + 1;
            end
            // vsync falling edge starts the next frame
            if (prev_vs && !o_vga_vs) begin
                check_value("active lines per frame", FRAME_LINES, y_cnt);
                frame_num = frame_num + 1;
                y_cnt = 0;
            end
        end
        rst_d = i_rst_n;
        prev_hs = o_vga_hs;
        prev_vs = o_vga_vs;
        prev_blank = o_vga_blank_n;
    end

    initial begin
        i_rst_n            = 1'b0;
        i_handwrite        = '0;
        i_digit_answered   = '0;
        i_digit_identified = 1'b0;
        load_golden();
        if (fd == 0) begin
            $display("golden file verification/digit_view_golden.txt could not be opened");
            errors = errors + 1;
        end else begin
            check_value("golden sample count", MAX_SAMPLES, n_samples);
            @(posedge i_clk);
            i_handwrite        <= gold_hw;
            i_digit_answered   <= gold_answer;
            i_digit_identified <= gold_ident;
            // three cycles of reset in total
            repeat (2) @(posedge i_clk);
            i_rst_n <= 1'b1;
            wait (frame_num == 2);
            check_value("golden samples reached", n_samples, hits);
            check_value("frames with hex checks", 2, hex_checks);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // two frames plus reset fit well inside three frame times
    initial begin
        #(3 * FRAME_CYCLES * CLK_PERIOD);
        $display("timeout, the raster did not complete two frames in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
